// ==== hw/core_pkg.sv ====
package core_pkg;

  // --------------------------------------------------------------------------
  // Widths and sizes
  // --------------------------------------------------------------------------

  // Data path width, one machine word
  localparam int XLEN = 32;

  // Register index width and register count
  localparam int REG_ADDR_BITS = 5;
  localparam int NR_GPR = 32;

  // Issue queue entries, any power of two of at least 2
  localparam int ISSUE_DEPTH = 4;

  // Queue pointer and fill count widths, derived from the depth
  localparam int QUEUE_PTR_BITS = $clog2(ISSUE_DEPTH);
  localparam int QUEUE_CNT_BITS = QUEUE_PTR_BITS + 1;

  // I-type immediate before sign extension
  localparam int IMM_BITS = 12;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // Operations carried from the decoder to the commit unit
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_ADDI,
    OP_ILLEGAL
  } alu_op_e;

endpackage

// ==== hw/issue_if.sv ====
`timescale 1ns/1ps

// One decoded instruction with a valid/ready handshake
interface issue_if;
  import core_pkg::*;

  logic                     valid;
  logic                     ready;
  alu_op_e                  op;
  logic [REG_ADDR_BITS-1:0] rd;
  logic [REG_ADDR_BITS-1:0] rs1;
  logic [REG_ADDR_BITS-1:0] rs2;
  // Already sign-extended
  logic [XLEN-1:0]          imm;

  modport producer (
    output valid, op, rd, rs1, rs2, imm,
    input  ready
  );

  modport consumer (
    input  valid, op, rd, rs1, rs2, imm,
    output ready
  );

endinterface

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     instr_valid_i,
  input  logic [core_pkg::XLEN-1:0] instr_i,
  output logic                     instr_ready_o,
  issue_if.producer                issue_o
);
  import core_pkg::*;

  opcode_e                  opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  alu_op_e                  dec_op;
  logic [REG_ADDR_BITS-1:0] dec_rd;
  logic [XLEN-1:0]          dec_imm;
  logic                     accept;

  logic                     valid_q;
  alu_op_e                  op_q;
  logic [REG_ADDR_BITS-1:0] rd_q;
  logic [REG_ADDR_BITS-1:0] rs1_q;
  logic [REG_ADDR_BITS-1:0] rs2_q;
  logic [XLEN-1:0]          imm_q;

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------
  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // I-type immediate, sign bit is instr[31]
  assign dec_imm = {{(XLEN - IMM_BITS){instr_i[31]}}, instr_i[31 -: IMM_BITS]};

  always_comb begin
    dec_op = OP_ILLEGAL;
    case (opcode)
      OPC_OP: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec_op = OP_ADD;
          {7'b0100000, 3'b000}: dec_op = OP_SUB;
          {7'b0000000, 3'b100}: dec_op = OP_XOR;
          {7'b0000000, 3'b110}: dec_op = OP_OR;
          {7'b0000000, 3'b111}: dec_op = OP_AND;
          default:              dec_op = OP_ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          dec_op = OP_ADDI;
        end
      end
      default: dec_op = OP_ILLEGAL;
    endcase
    // Illegal words never name a destination
    dec_rd = (dec_op == OP_ILLEGAL) ? '0 : instr_i[11:7];
  end

  // --------------------------------------------------------------------------
  // One-entry output register
  // --------------------------------------------------------------------------
  assign instr_ready_o = ~valid_q | issue_o.ready;
  assign accept        = instr_valid_i & instr_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (issue_o.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= dec_op;
      rd_q  <= dec_rd;
      rs1_q <= instr_i[19:15];
      rs2_q <= instr_i[24:20];
      imm_q <= dec_imm;
    end
  end

  assign issue_o.valid = valid_q;
  assign issue_o.op    = op_q;
  assign issue_o.rd    = rd_q;
  assign issue_o.rs1   = rs1_q;
  assign issue_o.rs2   = rs2_q;
  assign issue_o.imm   = imm_q;

endmodule

// ==== hw/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue (
  input  logic      clk_i,
  input  logic      rst_ni,
  issue_if.consumer enq_i,
  issue_if.producer deq_o
);
  import core_pkg::*;

  // Stored form of one decoded instruction
  typedef struct packed {
    alu_op_e                  op;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [XLEN-1:0]          imm;
  } entry_t;

  entry_t                    mem_q [ISSUE_DEPTH];
  entry_t                    head;
  logic [QUEUE_PTR_BITS-1:0] rd_ptr_q;
  logic [QUEUE_PTR_BITS-1:0] wr_ptr_q;
  logic [QUEUE_CNT_BITS-1:0] count_q;
  logic                      push;
  logic                      pop;

  assign enq_i.ready = (count_q != QUEUE_CNT_BITS'(ISSUE_DEPTH));
  assign deq_o.valid = (count_q != '0);

  assign push = enq_i.valid & enq_i.ready;
  assign pop  = deq_o.valid & deq_o.ready;

  // --------------------------------------------------------------------------
  // Pointers and fill count
  // --------------------------------------------------------------------------
  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= '{op: enq_i.op, rd: enq_i.rd, rs1: enq_i.rs1,
                           rs2: enq_i.rs2, imm: enq_i.imm};
    end
  end

  assign head      = mem_q[rd_ptr_q];
  assign deq_o.op  = head.op;
  assign deq_o.rd  = head.rd;
  assign deq_o.rs1 = head.rs1;
  assign deq_o.rs2 = head.rs2;
  assign deq_o.imm = head.imm;

endmodule

// ==== hw/gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [core_pkg::REG_ADDR_BITS-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_BITS-1:0] raddr_b_i,
  input  logic [core_pkg::REG_ADDR_BITS-1:0] waddr_i,
  input  logic                              we_i,
  input  logic [core_pkg::XLEN-1:0]          wdata_i,
  output logic [core_pkg::XLEN-1:0]          rdata_a_o,
  output logic [core_pkg::XLEN-1:0]          rdata_b_o
);
  import core_pkg::*;

  logic [XLEN-1:0] regs_q [NR_GPR];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_GPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read ports
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== hw/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  issue_if.consumer                         issue_i,
  output logic                              commit_valid_o,
  input  logic                              commit_ready_i,
  output logic [core_pkg::REG_ADDR_BITS-1:0] commit_waddr_o,
  output logic [core_pkg::XLEN-1:0]          commit_wdata_o,
  output logic                              commit_exc_o
);
  import core_pkg::*;

  logic [XLEN-1:0]          rs1_data;
  logic [XLEN-1:0]          rs2_data;
  logic [XLEN-1:0]          result;
  logic                     take;
  logic                     illegal;

  logic                     valid_q;
  logic [REG_ADDR_BITS-1:0] waddr_q;
  logic [XLEN-1:0]          wdata_q;
  logic                     exc_q;

  // --------------------------------------------------------------------------
  // Operand read and execute
  // --------------------------------------------------------------------------
  gpr_file i_gpr_file (
    .clk_i     ( clk_i                    ),
    .rst_ni    ( rst_ni                   ),
    .raddr_a_i ( issue_i.rs1              ),
    .raddr_b_i ( issue_i.rs2              ),
    .waddr_i   ( issue_i.rd               ),
    .we_i      ( take & ~illegal          ),
    .wdata_i   ( result                   ),
    .rdata_a_o ( rs1_data                 ),
    .rdata_b_o ( rs2_data                 )
  );

  assign illegal = (issue_i.op == OP_ILLEGAL);

  // Wraparound arithmetic, illegal ops yield zero
  always_comb begin
    case (issue_i.op)
      OP_ADD:  result = rs1_data + rs2_data;
      OP_SUB:  result = rs1_data - rs2_data;
      OP_XOR:  result = rs1_data ^ rs2_data;
      OP_OR:   result = rs1_data | rs2_data;
      OP_AND:  result = rs1_data & rs2_data;
      OP_ADDI: result = rs1_data + issue_i.imm;
      default: result = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Commit register
  // --------------------------------------------------------------------------
  // New entry only when the slot is free or drains this cycle
  assign issue_i.ready = ~valid_q | commit_ready_i;
  assign take          = issue_i.valid & issue_i.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (commit_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // rd is already zero for illegal entries
  always_ff @(posedge clk_i) begin
    if (take) begin
      waddr_q <= issue_i.rd;
      wdata_q <= result;
      exc_q   <= illegal;
    end
  end

  assign commit_valid_o = valid_q;
  assign commit_waddr_o = waddr_q;
  assign commit_wdata_o = wdata_q;
  assign commit_exc_o   = exc_q;

endmodule

// ==== hw/tiny_core.sv ====
`timescale 1ns/1ps

module tiny_core (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Instruction entry
  input  logic                              instr_valid_i,
  input  logic [core_pkg::XLEN-1:0]          instr_i,
  output logic                              instr_ready_o,
  // Commit port
  output logic                              commit_valid_o,
  input  logic                              commit_ready_i,
  output logic [core_pkg::REG_ADDR_BITS-1:0] commit_waddr_o,
  output logic [core_pkg::XLEN-1:0]          commit_wdata_o,
  output logic                              commit_exc_o
);

  // --------------------------------------------------------------------------
  // Decoder to queue, queue to commit
  // --------------------------------------------------------------------------
  issue_if dec_q ();
  issue_if q_cmt ();

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------
  instr_decoder i_instr_decoder (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .instr_ready_o ( instr_ready_o ),
    .issue_o       ( dec_q         )
  );

  // --------------------------------------------------------------------------
  // Issue
  // --------------------------------------------------------------------------
  issue_queue i_issue_queue (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni ),
    .enq_i  ( dec_q  ),
    .deq_o  ( q_cmt  )
  );

  // --------------------------------------------------------------------------
  // Execute and commit
  // --------------------------------------------------------------------------
  commit_unit i_commit_unit (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .issue_i        ( q_cmt          ),
    .commit_valid_o ( commit_valid_o ),
    .commit_ready_i ( commit_ready_i ),
    .commit_waddr_o ( commit_waddr_o ),
    .commit_wdata_o ( commit_wdata_o ),
    .commit_exc_o   ( commit_exc_o   )
  );

endmodule

// ==== tb/core_properties.sv ====
`timescale 1ns/1ps

module core_properties (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic                               commit_valid_i,
  input logic                               commit_ready_i,
  input logic [core_pkg::REG_ADDR_BITS-1:0] commit_waddr_i,
  input logic [core_pkg::XLEN-1:0]          commit_wdata_i,
  input logic                               commit_exc_i
);

  // --------------------------------------------------------------------------
  // Handshake stability
  // --------------------------------------------------------------------------
  // Stalled commit holds every field until accepted
  commit_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (commit_valid_i && !commit_ready_i) |=>
      (commit_valid_i && $stable(commit_waddr_i) && $stable(commit_wdata_i) &&
       $stable(commit_exc_i))
  ) else $error("Commit port changed while stalled");

  // --------------------------------------------------------------------------
  // Commit contents
  // --------------------------------------------------------------------------
  exc_zero_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (commit_valid_i && commit_exc_i) |-> (commit_waddr_i == '0 && commit_wdata_i == '0)
  ) else $error("Exception commit with nonzero address or data");

  // Nothing commits during reset
  reset_quiet_a: assert property (
    @(posedge clk_i) !rst_ni |-> !commit_valid_i
  ) else $error("Commit valid while reset is asserted");

endmodule

bind tiny_core core_properties i_core_properties (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .commit_valid_i ( commit_valid_o ),
  .commit_ready_i ( commit_ready_i ),
  .commit_waddr_i ( commit_waddr_o ),
  .commit_wdata_i ( commit_wdata_o ),
  .commit_exc_i   ( commit_exc_o   )
);

// ==== tb/tb_tiny_core.sv ====
`timescale 1ns/1ps

module tb_tiny_core;
  import core_pkg::*;

  localparam int TIMEOUT_CYCLES = 500;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     instr_valid_i;
  logic [XLEN-1:0]          instr_i;
  logic                     instr_ready_o;
  logic                     commit_valid_o;
  logic                     commit_ready_i;
  logic [REG_ADDR_BITS-1:0] commit_waddr_o;
  logic [XLEN-1:0]          commit_wdata_o;
  logic                     commit_exc_o;

  // Stimulus table with one row per instruction
  logic [XLEN-1:0]          prog_word [$];
  logic [REG_ADDR_BITS-1:0] exp_waddr [$];
  logic [XLEN-1:0]          exp_wdata [$];
  logic                     exp_exc   [$];

  int mismatch_count;
  int other_count;
  bit random_ready;
  bit stall_seen;

  tiny_core dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_i        ( instr_i        ),
    .instr_ready_o  ( instr_ready_o  ),
    .commit_valid_o ( commit_valid_o ),
    .commit_ready_i ( commit_ready_i ),
    .commit_waddr_o ( commit_waddr_o ),
    .commit_wdata_o ( commit_wdata_o ),
    .commit_exc_o   ( commit_exc_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Encoding and table helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] funct3, input logic [4:0] rd,
                                         input logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  task automatic add_row(input logic [31:0] word, input logic [4:0] waddr,
                         input logic [31:0] wdata, input logic exc);
    prog_word.push_back(word);
    exp_waddr.push_back(waddr);
    exp_wdata.push_back(wdata);
    exp_exc.push_back(exc);
  endtask

  // Rows only read registers written above them
  task automatic build_table();
    add_row(i_type(12'd100, 5'd0, 3'd0, 5'd1, 7'h13), 5'd1, 32'h0000_0064, 1'b0);
    add_row(i_type(12'hff9, 5'd0, 3'd0, 5'd2, 7'h13), 5'd2, 32'hffff_fff9, 1'b0);
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 5'd3, 32'h0000_005d, 1'b0);
    add_row(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd4), 5'd4, 32'hffff_ff95, 1'b0);
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd5), 5'd5, 32'hffff_ff9d, 1'b0);
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd6), 5'd6, 32'hffff_fffd, 1'b0);
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd7), 5'd7, 32'h0000_0060, 1'b0);
    add_row(i_type(12'h7ff, 5'd0, 3'd0, 5'd8, 7'h13), 5'd8, 32'h0000_07ff, 1'b0);
    add_row(i_type(12'h800, 5'd0, 3'd0, 5'd9, 7'h13), 5'd9, 32'hffff_f800, 1'b0);
    add_row(r_type(7'h20, 5'd9, 5'd0, 3'd0, 5'd10), 5'd10, 32'h0000_0800, 1'b0);
    add_row(r_type(7'h00, 5'd8, 5'd8, 3'd0, 5'd11), 5'd11, 32'h0000_0ffe, 1'b0);
    add_row(i_type(12'hfff, 5'd0, 3'd0, 5'd12, 7'h13), 5'd12, 32'hffff_ffff, 1'b0);
    add_row(r_type(7'h00, 5'd12, 5'd12, 3'd0, 5'd13), 5'd13, 32'hffff_fffe, 1'b0);
    add_row(i_type(12'h001, 5'd12, 3'd0, 5'd14, 7'h13), 5'd14, 32'h0000_0000, 1'b0);
    add_row(i_type(12'h800, 5'd9, 3'd0, 5'd15, 7'h13), 5'd15, 32'hffff_f000, 1'b0);
    // Write to x0, then reads of x0
    add_row(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd0), 5'd0, 32'h0000_00c8, 1'b0);
    add_row(i_type(12'd5, 5'd0, 3'd0, 5'd16, 7'h13), 5'd16, 32'h0000_0005, 1'b0);
    add_row(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd17), 5'd17, 32'h0000_0064, 1'b0);
    // Illegal SLLI, MUL, LW and all-zero words
    add_row(i_type(12'h003, 5'd1, 3'd1, 5'd1, 7'h13), 5'd0, 32'h0000_0000, 1'b1);
    add_row(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd3), 5'd0, 32'h0000_0000, 1'b1);
    add_row(i_type(12'h000, 5'd1, 3'd2, 5'd2, 7'h03), 5'd0, 32'h0000_0000, 1'b1);
    add_row(32'h0000_0000, 5'd0, 32'h0000_0000, 1'b1);
    // Registers named by the illegal words keep their values
    add_row(i_type(12'h000, 5'd1, 3'd0, 5'd18, 7'h13), 5'd18, 32'h0000_0064, 1'b0);
    add_row(r_type(7'h00, 5'd2, 5'd3, 3'd0, 5'd19), 5'd19, 32'h0000_0056, 1'b0);
    add_row(r_type(7'h20, 5'd6, 5'd7, 3'd0, 5'd20), 5'd20, 32'h0000_0063, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // Drivers and checkers acting at falling edges
  // --------------------------------------------------------------------------
  task automatic send_instr(input logic [XLEN-1:0] word);
    int waited;
    waited = 0;
    instr_valid_i = 1'b1;
    instr_i       = word;
    // instr_ready_o only moves at rising edges
    while (!instr_ready_o && waited < TIMEOUT_CYCLES) begin
      stall_seen = 1'b1;
      @(negedge clk_i);
      waited++;
    end
    assert (waited < TIMEOUT_CYCLES) else begin
      $display("Timeout: instruction %h was never accepted", word);
      other_count++;
    end
    @(negedge clk_i);
  endtask

  task automatic feed_table();
    for (int i = 0; i < prog_word.size(); i++) begin
      send_instr(prog_word[i]);
    end
    instr_valid_i = 1'b0;
  endtask

  task automatic check_commit(input int idx);
    assert (commit_waddr_o == exp_waddr[idx] && commit_wdata_o == exp_wdata[idx] &&
            commit_exc_o == exp_exc[idx]) else begin
      $display("MISMATCH at %0t: row %0d got x%0d=%h exc=%b, expected x%0d=%h exc=%b",
               $time, idx, commit_waddr_o, commit_wdata_o, commit_exc_o,
               exp_waddr[idx], exp_wdata[idx], exp_exc[idx]);
      mismatch_count++;
    end
  endtask

  task automatic collect_commits();
    int idx;
    int idle;
    idx  = 0;
    idle = 0;
    while (idx < prog_word.size() && idle < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      commit_ready_i = random_ready ? ($urandom_range(3) == 0) : 1'b1;
      if (commit_valid_o && commit_ready_i) begin
        check_commit(idx);
        idx++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    assert (idx == prog_word.size()) else begin
      $display("Timeout: only %0d of %0d commits arrived", idx, prog_word.size());
      other_count++;
    end
  endtask

  // No commit may follow the last row
  task automatic check_drained();
    commit_ready_i = 1'b1;
    repeat (8) begin
      @(negedge clk_i);
      assert (!commit_valid_o) else begin
        $display("MISMATCH at %0t: extra commit to x%0d after the table", $time,
                 commit_waddr_o);
        mismatch_count++;
      end
    end
  endtask

  task automatic run_pass(input bit use_random);
    random_ready = use_random;
    stall_seen   = 1'b0;
    fork
      feed_table();
      collect_commits();
    join
    check_drained();
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(32'h332c_cc40));
    rst_ni         = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    commit_ready_i = 1'b1;
    mismatch_count = 0;
    other_count    = 0;
    random_ready   = 1'b0;
    stall_seen     = 1'b0;
    build_table();
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!commit_valid_o && instr_ready_o) else begin
      $display("MISMATCH at %0t: after reset commit_valid_o=%b instr_ready_o=%b", $time,
               commit_valid_o, instr_ready_o);
      mismatch_count++;
    end
    // Full rate, then random back-pressure over the same table
    run_pass(1'b0);
    run_pass(1'b1);
    assert (stall_seen) else begin
      $display("Back-pressure never filled the queue, instr_ready_o stayed high");
      other_count++;
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hw/core_pkg.sv
hw/issue_if.sv
hw/instr_decoder.sv
hw/issue_queue.sv
hw/gpr_file.sv
hw/commit_unit.sv
hw/tiny_core.sv
tb/core_properties.sv
tb/tb_tiny_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tiny_core testbench with Verilator, then scan the log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tiny_core \
  --Mdir obj_dir -o tb_tiny_core -f list.f > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_tiny_core > sim.log 2>&1 || echo "Simulator returned an error status"

grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation did not complete, see sim.log"; exit 1; }
echo "Simulation passed"
